// File: all.f
+incdir+verilog
+incdir+dv
verilog/id_pkg.sv
verilog/id_decoder.sv
verilog/id_operand_sel.sv
verilog/id_issue.sv
verilog/id_stage.sv
dv/tb_id_stage.sv

// File: dv/id_tests.svh
// --------------------
// MIPS encodings
function automatic inst_t r_word(input reg_addr_t rs, input reg_addr_t rt,
                                 input reg_addr_t rd, input logic [4:0] sa,
                                 input logic [5:0] fn);
    return {`ID_OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic inst_t i_word(input logic [5:0] op, input reg_addr_t rs,
                                 input reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// register-register op, no forwarding
task automatic r_case(input logic [5:0] fn, input aluop_t op, input alusel_t sel);
    logic [31:0] r;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    next_rand(r);
    rs = r[4:0];
    rt = r[9:5];
    rd = r[14:10];
    present(r_word(rs, rt, rd, 5'd0, fn));
    check_word("reg1_read_o", 1, reg1_read_o);
    check_word("reg2_read_o", 1, reg2_read_o);
    check_word("reg1_addr_o", rs, reg1_addr_o);
    check_word("reg2_addr_o", rt, reg2_addr_o);
    next_edge();
    check_word("aluop_o", op, aluop_o);
    check_word("alusel_o", sel, alusel_o);
    check_word("wd_o", rd, wd_o);
    check_word("wreg_o", 1, wreg_o);
    check_word("reg1_o", rf_data(rs), reg1_o);
    check_word("reg2_o", rf_data(rt), reg2_o);
    check_word("inst_invalid_o", 0, inst_invalid_o);
endtask

task automatic i_case(input logic [5:0] opc, input aluop_t op, input logic upper);
    logic [31:0] r;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [15:0] imm;
    next_rand(r);
    rs  = r[4:0];
    rt  = r[9:5];
    imm = r[31:16];
    present(i_word(opc, rs, rt, imm));
    check_word("reg1_read_o", 1, reg1_read_o);
    check_word("reg2_read_o", 0, reg2_read_o);
    check_word("reg1_addr_o", rs, reg1_addr_o);
    next_edge();
    check_word("aluop_o", op, aluop_o);
    check_word("alusel_o", `ID_SEL_LOGIC, alusel_o);
    check_word("wd_o", rt, wd_o);
    check_word("wreg_o", 1, wreg_o);
    check_word("reg1_o", rf_data(rs), reg1_o);
    check_word("reg2_o", upper ? {imm, 16'h0000} : {16'h0000, imm}, reg2_o);
endtask

task automatic sa_case(input logic [5:0] fn, input aluop_t op);
    logic [31:0] r;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  sa;
    next_rand(r);
    rt = r[4:0];
    rd = r[9:5];
    sa = r[14:10];
    present({11'd0, rt, rd, sa, fn});
    check_word("reg1_read_o", 0, reg1_read_o);
    check_word("reg2_read_o", 1, reg2_read_o);
    check_word("reg2_addr_o", rt, reg2_addr_o);
    next_edge();
    check_word("aluop_o", op, aluop_o);
    check_word("alusel_o", `ID_SEL_SHIFT, alusel_o);
    check_word("wd_o", rd, wd_o);
    check_word("wreg_o", 1, wreg_o);
    check_word("reg1_o", {27'd0, sa}, reg1_o);
    check_word("reg2_o", rf_data(rt), reg2_o);
endtask

// AND rs, rt with forwarding already set up
task automatic operand_pair(input reg_addr_t rs, input reg_addr_t rt,
                            input word_t exp1, input word_t exp2);
    present(r_word(rs, rt, 5'd3, 5'd0, `ID_FN_AND));
    next_edge();
    check_word("reg1_o", exp1, reg1_o);
    check_word("reg2_o", exp2, reg2_o);
endtask

task automatic move_case(input logic [5:0] fn, input aluop_t op, input logic rt_zero,
                         input logic exp_wreg);
    reg_addr_t rt;
    rt = 5'd9;
    forward(rt_zero, rt, 32'h0, 1'b0, '0, '0);  // zero arrives only by EX forward
    present(r_word(5'd4, rt, 5'd12, 5'd0, fn));
    next_edge();
    check_word("aluop_o", op, aluop_o);
    check_word("alusel_o", `ID_SEL_MOVE, alusel_o);
    check_word("wreg_o", exp_wreg, wreg_o);
    check_word("reg2_o", rt_zero ? 32'h0 : rf_data(rt), reg2_o);
endtask

// --------------------
task automatic reset_values();
    begin_test("reset_values");
    present(i_word(6'b000010, 5'd5, 5'd6, 16'h00c3));  // J, decodes as invalid
    check_word("reg1_read_o", 0, reg1_read_o);
    check_word("reg2_read_o", 0, reg2_read_o);
    next_edge();
    check_word("inst_invalid_o", 0, inst_invalid_o);
    // ports held off, so the immediate lands on both operands
    present(i_word(`ID_OP_ORI, 5'd1, 5'd2, 16'h5a3c));
    check_word("reg1_read_o", 0, reg1_read_o);
    check_word("reg2_read_o", 0, reg2_read_o);
    next_edge();
    check_word("wreg_o", 0, wreg_o);
    check_word("inst_invalid_o", 0, inst_invalid_o);
    check_word("aluop_o", `ID_ALUOP_NOP, aluop_o);
    check_word("alusel_o", `ID_SEL_NOP, alusel_o);
    check_word("reg1_o", 0, reg1_o);
    check_word("reg2_o", 0, reg2_o);
    check_word("wd_o", 0, wd_o);
    end_test();
endtask

task automatic rtype_ops();
    begin_test("rtype_ops");
    r_case(`ID_FN_AND, `ID_ALUOP_AND, `ID_SEL_LOGIC);
    r_case(`ID_FN_OR, `ID_ALUOP_OR, `ID_SEL_LOGIC);
    r_case(`ID_FN_XOR, `ID_ALUOP_XOR, `ID_SEL_LOGIC);
    r_case(`ID_FN_NOR, `ID_ALUOP_NOR, `ID_SEL_LOGIC);
    r_case(`ID_FN_SLT, `ID_ALUOP_SLT, `ID_SEL_ARITH);
    r_case(`ID_FN_SLTU, `ID_ALUOP_SLTU, `ID_SEL_ARITH);
    r_case(`ID_FN_ADD, `ID_ALUOP_ADD, `ID_SEL_ARITH);
    r_case(`ID_FN_ADDU, `ID_ALUOP_ADDU, `ID_SEL_ARITH);
    r_case(`ID_FN_SUB, `ID_ALUOP_SUB, `ID_SEL_ARITH);
    r_case(`ID_FN_SUBU, `ID_ALUOP_SUBU, `ID_SEL_ARITH);
    end_test();
endtask

task automatic itype_ops();
    begin_test("itype_ops");
    i_case(`ID_OP_ORI, `ID_ALUOP_OR, 1'b0);
    i_case(`ID_OP_ANDI, `ID_ALUOP_AND, 1'b0);
    i_case(`ID_OP_XORI, `ID_ALUOP_XOR, 1'b0);
    i_case(`ID_OP_LUI, `ID_ALUOP_OR, 1'b1);
    end_test();
endtask

task automatic shift_ops();
    begin_test("shift_ops");
    sa_case(`ID_FN_SLL, `ID_ALUOP_SLL);
    sa_case(`ID_FN_SRL, `ID_ALUOP_SRL);
    sa_case(`ID_FN_SRA, `ID_ALUOP_SRA);
    r_case(`ID_FN_SLLV, `ID_ALUOP_SLL, `ID_SEL_SHIFT);
    r_case(`ID_FN_SRLV, `ID_ALUOP_SRL, `ID_SEL_SHIFT);
    r_case(`ID_FN_SRAV, `ID_ALUOP_SRA, `ID_SEL_SHIFT);
    end_test();
endtask

task automatic forward_paths();
    logic [31:0] r;
    reg_addr_t   rs;
    reg_addr_t   rt;
    begin_test("forward_paths");
    next_rand(r);
    rs = r[4:0];
    rt = rs ^ 5'd1;  // keep the two ports apart
    forward(1'b1, rs, 32'hdead_0001, 1'b1, rs, 32'hbeef_0002);
    operand_pair(rs, rt, 32'hdead_0001, rf_data(rt));
    forward(1'b0, rs, 32'hdead_0003, 1'b1, rt, 32'hbeef_0004);
    operand_pair(rs, rt, rf_data(rs), 32'hbeef_0004);
    forward(1'b0, rs, 32'hdead_0005, 1'b0, rt, 32'hbeef_0006);
    operand_pair(rs, rt, rf_data(rs), rf_data(rt));
    forward(1'b0, '0, '0, 1'b0, '0, '0);
    end_test();
endtask

task automatic move_and_invalid();
    begin_test("move_and_invalid");
    move_case(`ID_FN_MOVN, `ID_ALUOP_MOVN, 1'b0, 1'b1);
    move_case(`ID_FN_MOVN, `ID_ALUOP_MOVN, 1'b1, 1'b0);
    move_case(`ID_FN_MOVZ, `ID_ALUOP_MOVZ, 1'b0, 1'b0);
    move_case(`ID_FN_MOVZ, `ID_ALUOP_MOVZ, 1'b1, 1'b1);
    forward(1'b0, '0, '0, 1'b0, '0, '0);
    present(i_word(6'b000010, 5'd7, 5'd8, 16'h1234));  // J, not decoded here
    next_edge();
    check_word("inst_invalid_o", 1, inst_invalid_o);
    check_word("wreg_o", 0, wreg_o);
    present(r_word(5'd7, 5'd8, 5'd9, 5'd0, 6'b001000));  // JR
    next_edge();
    check_word("inst_invalid_o", 1, inst_invalid_o);
    check_word("wreg_o", 0, wreg_o);
    end_test();
endtask

// File: dv/tb_id_stage.sv
`include "id_macros.svh"

module tb_id_stage;
    import id_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam int CLK_HALF  = 4;

    logic      clk;
    logic      rst_i;
    inst_t     inst_i;
    word_t     reg1_data_i;
    word_t     reg2_data_i;
    logic      ex_wreg_i;
    reg_addr_t ex_wd_i;
    word_t     ex_wdata_i;
    logic      mem_wreg_i;
    reg_addr_t mem_wd_i;
    word_t     mem_wdata_i;

    logic      reg1_read_o;
    reg_addr_t reg1_addr_o;
    logic      reg2_read_o;
    reg_addr_t reg2_addr_o;
    aluop_t    aluop_o;
    alusel_t   alusel_o;
    word_t     reg1_o;
    word_t     reg2_o;
    reg_addr_t wd_o;
    logic      wreg_o;
    logic      inst_invalid_o;

    logic [31:0] rng_state;
    int          error_cnt;
    int          tests_run;
    int          tests_failed;
    int          test_err_start;
    string       cur_test;

    id_stage dut0 (
        .clk            (clk),
        .rst_i          (rst_i),
        .inst_i         (inst_i),
        .reg1_data_i    (reg1_data_i),
        .reg2_data_i    (reg2_data_i),
        .reg1_read_o    (reg1_read_o),
        .reg1_addr_o    (reg1_addr_o),
        .reg2_read_o    (reg2_read_o),
        .reg2_addr_o    (reg2_addr_o),
        .ex_wreg_i      (ex_wreg_i),
        .ex_wd_i        (ex_wd_i),
        .ex_wdata_i     (ex_wdata_i),
        .mem_wreg_i     (mem_wreg_i),
        .mem_wd_i       (mem_wd_i),
        .mem_wdata_i    (mem_wdata_i),
        .aluop_o        (aluop_o),
        .alusel_o       (alusel_o),
        .reg1_o         (reg1_o),
        .reg2_o         (reg2_o),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .inst_invalid_o (inst_invalid_o)
    );

    always #CLK_HALF clk = ~clk;

    // --------------------
    // register file model, answers in the same cycle
    function automatic word_t rf_data(input reg_addr_t a);
        return (word_t'(a) * 32'h0101_0101) ^ 32'h0332_92e0;
    endfunction

    assign reg1_data_i = rf_data(reg1_addr_o);
    assign reg2_data_i = rf_data(reg2_addr_o);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng_state = xorshift(rng_state);
        v = rng_state;
    endtask

    // --------------------
    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
            error_cnt++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = error_cnt;
        tests_run++;
    endtask

    task automatic end_test();
        if (error_cnt == test_err_start) begin
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", cur_test, error_cnt - test_err_start);
        end
    endtask

    // drive at edge + 1, read-port signals settle before edge + 3
    task automatic present(input inst_t inst);
        inst_i = inst;
        #2;
    endtask

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic forward(input logic ew, input reg_addr_t ea, input word_t ed,
                           input logic mw, input reg_addr_t ma, input word_t md);
        ex_wreg_i   = ew;
        ex_wd_i     = ea;
        ex_wdata_i  = ed;
        mem_wreg_i  = mw;
        mem_wd_i    = ma;
        mem_wdata_i = md;
    endtask

    `include "id_tests.svh"

    // --------------------
    initial begin
        clk          = 1'b0;
        rst_i        = 1'b1;
        inst_i       = '0;
        rng_state    = 32'h0332_92e0;
        error_cnt    = 0;
        tests_run    = 0;
        tests_failed = 0;
        forward(1'b0, '0, '0, 1'b0, '0, '0);

        repeat (3) @(posedge clk);
        #1;
        reset_values();  // last two reset edges happen in here
        rst_i = 1'b0;

        rtype_ops();
        itype_ops();
        shift_ops();
        forward_paths();
        move_and_invalid();

        $display("summary: %0d tests run, %0d tests failed, %0d errors",
                 tests_run, tests_failed, error_cnt);
        if (error_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(200 * NUM_TESTS * 2 * CLK_HALF);
        $display("watchdog expired before the test sequence finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verilog/id_decoder.sv
`include "id_macros.svh"

module id_decoder (
    input  logic              rst_i,
    input  id_pkg::inst_t     inst_i,
    output id_pkg::aluop_t    aluop_o,
    output id_pkg::alusel_t   alusel_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output logic              cond_nz_o,
    output logic              cond_z_o,
    output logic              reg1_read_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    output id_pkg::word_t     imm_o,
    output logic              invalid_o
);
    import id_pkg::*;

    // --------------------
    // instruction fields
    logic [5:0]  op;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  shamt;
    logic [5:0]  funct;
    logic [15:0] imm16;

    logic        r_hit;  // SPECIAL register-register op matched
    logic        valid;
    logic        rd1;
    logic        rd2;

    assign op    = inst_i[31:26];
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign shamt = inst_i[10:6];
    assign funct = inst_i[5:0];
    assign imm16 = inst_i[15:0];

    assign reg1_addr_o = rs;
    assign reg2_addr_o = rt;
    assign reg1_read_o = rd1 & ~rst_i;  // no port activity in reset
    assign reg2_read_o = rd2 & ~rst_i;
    assign invalid_o   = ~valid;

    // --------------------
    always_comb begin
        aluop_o   = `ID_ALUOP_NOP;
        alusel_o  = `ID_SEL_NOP;
        wd_o      = rd;
        wreg_o    = 1'b0;
        cond_nz_o = 1'b0;
        cond_z_o  = 1'b0;
        rd1       = 1'b0;
        rd2       = 1'b0;
        imm_o     = '0;
        valid     = 1'b0;
        r_hit     = 1'b0;

        case (op)
            `ID_OP_SPECIAL: begin
                if (shamt == 5'd0) begin
                    r_hit = 1'b1;
                    case (funct)
                        `ID_FN_AND: begin
                            aluop_o  = `ID_ALUOP_AND;
                            alusel_o = `ID_SEL_LOGIC;
                        end
                        `ID_FN_OR: begin
                            aluop_o  = `ID_ALUOP_OR;
                            alusel_o = `ID_SEL_LOGIC;
                        end
                        `ID_FN_XOR: begin
                            aluop_o  = `ID_ALUOP_XOR;
                            alusel_o = `ID_SEL_LOGIC;
                        end
                        `ID_FN_NOR: begin
                            aluop_o  = `ID_ALUOP_NOR;
                            alusel_o = `ID_SEL_LOGIC;
                        end
                        `ID_FN_SLLV: begin
                            aluop_o  = `ID_ALUOP_SLL;
                            alusel_o = `ID_SEL_SHIFT;
                        end
                        `ID_FN_SRLV: begin
                            aluop_o  = `ID_ALUOP_SRL;
                            alusel_o = `ID_SEL_SHIFT;
                        end
                        `ID_FN_SRAV: begin
                            aluop_o  = `ID_ALUOP_SRA;
                            alusel_o = `ID_SEL_SHIFT;
                        end
                        `ID_FN_MOVN: begin
                            aluop_o   = `ID_ALUOP_MOVN;
                            alusel_o  = `ID_SEL_MOVE;
                            cond_nz_o = 1'b1;  // write only if rt != 0
                        end
                        `ID_FN_MOVZ: begin
                            aluop_o  = `ID_ALUOP_MOVZ;
                            alusel_o = `ID_SEL_MOVE;
                            cond_z_o = 1'b1;
                        end
                        `ID_FN_SLT: begin
                            aluop_o  = `ID_ALUOP_SLT;
                            alusel_o = `ID_SEL_ARITH;
                        end
                        `ID_FN_SLTU: begin
                            aluop_o  = `ID_ALUOP_SLTU;
                            alusel_o = `ID_SEL_ARITH;
                        end
                        `ID_FN_ADD: begin
                            aluop_o  = `ID_ALUOP_ADD;
                            alusel_o = `ID_SEL_ARITH;
                        end
                        `ID_FN_ADDU: begin
                            aluop_o  = `ID_ALUOP_ADDU;
                            alusel_o = `ID_SEL_ARITH;
                        end
                        `ID_FN_SUB: begin
                            aluop_o  = `ID_ALUOP_SUB;
                            alusel_o = `ID_SEL_ARITH;
                        end
                        `ID_FN_SUBU: begin
                            aluop_o  = `ID_ALUOP_SUBU;
                            alusel_o = `ID_SEL_ARITH;
                        end
                        default: r_hit = 1'b0;
                    endcase
                end
                if (r_hit) begin
                    wreg_o = 1'b1;
                    rd1    = 1'b1;
                    rd2    = 1'b1;
                    valid  = 1'b1;
                end
            end
            `ID_OP_ORI, `ID_OP_ANDI, `ID_OP_XORI, `ID_OP_LUI: begin
                alusel_o = `ID_SEL_LOGIC;
                wd_o     = rt;
                wreg_o   = 1'b1;
                rd1      = 1'b1;
                valid    = 1'b1;
                imm_o    = {16'h0000, imm16};
                case (op)
                    `ID_OP_ANDI: aluop_o = `ID_ALUOP_AND;
                    `ID_OP_XORI: aluop_o = `ID_ALUOP_XOR;
                    default:     aluop_o = `ID_ALUOP_OR;
                endcase
                if (op == `ID_OP_LUI) begin
                    imm_o = {imm16, 16'h0000};  // lui is rs | (imm << 16)
                end
            end
            default: valid = 1'b0;
        endcase

        // immediate shifts, rs field must be zero
        if (inst_i[31:21] == 11'd0 &&
            (funct == `ID_FN_SLL || funct == `ID_FN_SRL || funct == `ID_FN_SRA)) begin
            case (funct)
                `ID_FN_SRL: aluop_o = `ID_ALUOP_SRL;
                `ID_FN_SRA: aluop_o = `ID_ALUOP_SRA;
                default:    aluop_o = `ID_ALUOP_SLL;
            endcase
            alusel_o   = `ID_SEL_SHIFT;
            wd_o       = rd;
            wreg_o     = 1'b1;
            rd1        = 1'b0;
            rd2        = 1'b1;
            imm_o      = '0;
            imm_o[4:0] = shamt;
            valid      = 1'b1;
        end
    end

endmodule

// File: verilog/id_issue.sv
`include "id_macros.svh"

module id_issue (
    input  logic              clk,
    input  logic              rst_i,
    input  id_pkg::aluop_t    aluop_i,
    input  id_pkg::alusel_t   alusel_i,
    input  id_pkg::reg_addr_t wd_i,
    input  logic              wreg_i,
    input  logic              cond_nz_i,
    input  logic              cond_z_i,
    input  logic              invalid_i,
    input  id_pkg::word_t     op1_i,
    input  id_pkg::word_t     op2_i,
    output id_pkg::aluop_t    aluop_o,
    output id_pkg::alusel_t   alusel_o,
    output id_pkg::word_t     reg1_o,
    output id_pkg::word_t     reg2_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output logic              inst_invalid_o
);

    logic op2_zero;
    logic wreg_final;

    // --------------------
    // MOVN / MOVZ condition on the forwarded rt value
    assign op2_zero   = (op2_i == '0);
    assign wreg_final = wreg_i && !(cond_nz_i && op2_zero) && !(cond_z_i && !op2_zero);

    // --------------------
    // ID/EX register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            aluop_o        <= `ID_ALUOP_NOP;
            alusel_o       <= `ID_SEL_NOP;
            reg1_o         <= '0;
            reg2_o         <= '0;
            wd_o           <= '0;
            wreg_o         <= 1'b0;
            inst_invalid_o <= 1'b0;
        end else begin
            aluop_o        <= aluop_i;
            alusel_o       <= alusel_i;
            reg1_o         <= op1_i;
            reg2_o         <= op2_i;
            wd_o           <= wd_i;
            wreg_o         <= wreg_final;
            inst_invalid_o <= invalid_i;
        end
    end

endmodule

// File: verilog/id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// --------------------
// widths
`define ID_WORD_W           32
`define ID_REG_ADDR_W       5
`define ID_ALUOP_W          8
`define ID_ALUSEL_W         3

// --------------------
// primary opcodes, inst[31:26]
`define ID_OP_SPECIAL       6'b000000
`define ID_OP_ANDI          6'b001100
`define ID_OP_ORI           6'b001101
`define ID_OP_XORI          6'b001110
`define ID_OP_LUI           6'b001111

// SPECIAL function codes, inst[5:0]
`define ID_FN_SLL           6'b000000
`define ID_FN_SRL           6'b000010
`define ID_FN_SRA           6'b000011
`define ID_FN_SLLV          6'b000100
`define ID_FN_SRLV          6'b000110
`define ID_FN_SRAV          6'b000111
`define ID_FN_MOVZ          6'b001010
`define ID_FN_MOVN          6'b001011
`define ID_FN_ADD           6'b100000
`define ID_FN_ADDU          6'b100001
`define ID_FN_SUB           6'b100010
`define ID_FN_SUBU          6'b100011
`define ID_FN_AND           6'b100100
`define ID_FN_OR            6'b100101
`define ID_FN_XOR           6'b100110
`define ID_FN_NOR           6'b100111
`define ID_FN_SLT           6'b101010
`define ID_FN_SLTU          6'b101011

// --------------------
// ALU operation codes
`define ID_ALUOP_NOP        8'b00000000
`define ID_ALUOP_AND        8'b00100100
`define ID_ALUOP_OR         8'b00100101
`define ID_ALUOP_XOR        8'b00100110
`define ID_ALUOP_NOR        8'b00100111
`define ID_ALUOP_SLL        8'b01111100
`define ID_ALUOP_SRL        8'b00000010
`define ID_ALUOP_SRA        8'b00000011
`define ID_ALUOP_SLT        8'b00101010
`define ID_ALUOP_SLTU       8'b00101011
`define ID_ALUOP_ADD        8'b00100000
`define ID_ALUOP_ADDU       8'b00100001
`define ID_ALUOP_SUB        8'b00100010
`define ID_ALUOP_SUBU       8'b00100011
`define ID_ALUOP_MOVN       8'b00001011
`define ID_ALUOP_MOVZ       8'b00001010

// result classes
`define ID_SEL_NOP          3'b000
`define ID_SEL_LOGIC        3'b001
`define ID_SEL_SHIFT        3'b010
`define ID_SEL_MOVE         3'b011
`define ID_SEL_ARITH        3'b100

`endif

// File: verilog/id_operand_sel.sv
module id_operand_sel (
    input  logic              read_i,
    input  id_pkg::reg_addr_t addr_i,
    input  id_pkg::word_t     reg_data_i,
    input  id_pkg::word_t     imm_i,
    input  logic              ex_wreg_i,
    input  id_pkg::reg_addr_t ex_wd_i,
    input  id_pkg::word_t     ex_wdata_i,
    input  logic              mem_wreg_i,
    input  id_pkg::reg_addr_t mem_wd_i,
    input  id_pkg::word_t     mem_wdata_i,
    output id_pkg::word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // pending writes to the register being read
    assign ex_hit  = ex_wreg_i && (ex_wd_i == addr_i);
    assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i);

    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_wdata_i;  // youngest result wins
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = reg_data_i;
        end
    end

endmodule

// File: verilog/id_pkg.sv
`include "id_macros.svh"

package id_pkg;

    // data word moving through the stage
    typedef logic [`ID_WORD_W-1:0] word_t;

    // raw instruction word
    typedef logic [`ID_WORD_W-1:0] inst_t;

    // register file index
    typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

    // operation code handed to EX
    typedef logic [`ID_ALUOP_W-1:0] aluop_t;

    // which EX result bank is written back
    typedef logic [`ID_ALUSEL_W-1:0] alusel_t;

endpackage

// File: verilog/id_stage.sv
module id_stage (
    input  logic              clk,
    input  logic              rst_i,
    input  id_pkg::inst_t     inst_i,

    // register file
    input  id_pkg::word_t     reg1_data_i,
    input  id_pkg::word_t     reg2_data_i,
    output logic              reg1_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg2_addr_o,

    // --------------------
    // forwarding from later stages
    input  logic              ex_wreg_i,
    input  id_pkg::reg_addr_t ex_wd_i,
    input  id_pkg::word_t     ex_wdata_i,
    input  logic              mem_wreg_i,
    input  id_pkg::reg_addr_t mem_wd_i,
    input  id_pkg::word_t     mem_wdata_i,

    // --------------------
    // to EX
    output id_pkg::aluop_t    aluop_o,
    output id_pkg::alusel_t   alusel_o,
    output id_pkg::word_t     reg1_o,
    output id_pkg::word_t     reg2_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output logic              inst_invalid_o
);
    import id_pkg::*;

    aluop_t    dec_aluop;
    alusel_t   dec_alusel;
    reg_addr_t dec_wd;
    logic      dec_wreg;
    logic      dec_cond_nz;
    logic      dec_cond_z;
    logic      dec_invalid;
    word_t     dec_imm;
    word_t     op1;
    word_t     op2;

    id_decoder u_dec (
        .rst_i       (rst_i),
        .inst_i      (inst_i),
        .aluop_o     (dec_aluop),
        .alusel_o    (dec_alusel),
        .wd_o        (dec_wd),
        .wreg_o      (dec_wreg),
        .cond_nz_o   (dec_cond_nz),
        .cond_z_o    (dec_cond_z),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .imm_o       (dec_imm),
        .invalid_o   (dec_invalid)
    );

    // one selector per read port
    id_operand_sel u_op1 (
        .read_i      (reg1_read_o),
        .addr_i      (reg1_addr_o),
        .reg_data_i  (reg1_data_i),
        .imm_i       (dec_imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (op1)
    );

    id_operand_sel u_op2 (
        .read_i      (reg2_read_o),
        .addr_i      (reg2_addr_o),
        .reg_data_i  (reg2_data_i),
        .imm_i       (dec_imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (op2)
    );

    id_issue u_issue (
        .clk            (clk),
        .rst_i          (rst_i),
        .aluop_i        (dec_aluop),
        .alusel_i       (dec_alusel),
        .wd_i           (dec_wd),
        .wreg_i         (dec_wreg),
        .cond_nz_i      (dec_cond_nz),
        .cond_z_i       (dec_cond_z),
        .invalid_i      (dec_invalid),
        .op1_i          (op1),
        .op2_i          (op2),
        .aluop_o        (aluop_o),
        .alusel_o       (alusel_o),
        .reg1_o         (reg1_o),
        .reg2_o         (reg2_o),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .inst_invalid_o (inst_invalid_o)
    );

endmodule
